// ==== Bender.yml ====
package:
  name: dcache

sources:
  - verilog/cpu_types_pkg.sv
  - verilog/dcache_pkg.sv
  - verilog/event_counter.sv
  - verilog/dcache_frame_array.sv
  - verilog/dcache_control_unit.sv
  - verilog/dcache.sv
  - target: test
    files:
      - test/dcache_mem_model.sv
      - test/dcache_tb.sv

// ==== files.f ====
verilog/cpu_types_pkg.sv
verilog/dcache_pkg.sv
verilog/event_counter.sv
verilog/dcache_frame_array.sv
verilog/dcache_control_unit.sv
verilog/dcache.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

// ==== test/dcache_mem_model.sv ====
`timescale 1ns/1ps

module dcache_mem_model #(
  parameter int DEPTH = 4096
) (
  input  logic                    CLK,
  input  logic                    nRST,
  input  cpu_types_pkg::mem_req_t mreq,
  output logic                    dwait,
  output cpu_types_pkg::word_t    dload,
  input  cpu_types_pkg::word_t    peek_addr,
  output cpu_types_pkg::word_t    peek_data
);

  localparam int AW = $clog2(DEPTH);

  cpu_types_pkg::word_t mem [DEPTH];
  logic [1:0]           stall;
  logic                 active;

  assign active = mreq.ren || mreq.wen;
  // stall cycles left before the current transfer completes
  assign dwait = active && (stall != 2'd0);
  assign dload = mem[mreq.addr[AW+1:2]];
  assign peek_data = mem[peek_addr[AW+1:2]];

  always @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      stall <= 2'd0;
    else if (active)
    begin
      if (stall != 2'd0)
        stall <= stall - 2'd1;
      else
      begin
        if (mreq.wen)
          mem[mreq.addr[AW+1:2]] = mreq.store;
        // delay for the next transfer
        stall <= 2'($urandom % 4);
      end
    end
  end

  task automatic preload(input int unsigned word_idx, input cpu_types_pkg::word_t value);
    mem[word_idx] = value;
  endtask

endmodule

// ==== test/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;

  localparam int N_REQ = 300;
  localparam int TEST_WORDS = 64;
  localparam int MEM_WORDS = 4096;
  localparam int TIMEOUT = 200;

  logic                       CLK;
  logic                       nRST;
  cpu_types_pkg::dcache_req_t dreq;
  logic                       dwait;
  cpu_types_pkg::word_t       dload;
  logic                       dhit;
  cpu_types_pkg::word_t       dmemload;
  logic                       flushed;
  cpu_types_pkg::mem_req_t    mreq;
  cpu_types_pkg::word_t       peek_addr;
  cpu_types_pkg::word_t       peek_data;

  // reference memory and tag/lru model
  cpu_types_pkg::word_t         ref_mem [MEM_WORDS];
  logic [dcache_pkg::TAG_W-1:0] model_tag [dcache_pkg::N_SETS][2];
  logic                         model_valid [dcache_pkg::N_SETS][2];
  logic                         model_dirty [dcache_pkg::N_SETS][2];
  logic                         model_lru [dcache_pkg::N_SETS];
  int unsigned                  model_hits;

  cpu_types_pkg::mem_req_t seen_q [$];
  cpu_types_pkg::mem_req_t expect_q [$];
  int                      error_count;
  int                      check_count;
  logic                    timed_out;

  dcache i_dcache (
    .CLK(CLK),
    .nRST(nRST),
    .dreq(dreq),
    .dwait(dwait),
    .dload(dload),
    .dhit(dhit),
    .dmemload(dmemload),
    .flushed(flushed),
    .mreq(mreq)
  );

  dcache_mem_model #(.DEPTH(MEM_WORDS)) i_mem (
    .CLK(CLK),
    .nRST(nRST),
    .mreq(mreq),
    .dwait(dwait),
    .dload(dload),
    .peek_addr(peek_addr),
    .peek_data(peek_data)
  );

  always #4 CLK = ~CLK;

  // completed bus transfers
  always @(posedge CLK)
  begin
    if (nRST && (mreq.ren || mreq.wen) && !dwait)
      seen_q.push_back(mreq);
  end

  task automatic compare_word(input string name, input cpu_types_pkg::word_t expected,
                              input cpu_types_pkg::word_t actual);
    check_count++;
    assert (actual === expected)
    else
    begin
      error_count++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic wait_for_dhit(input int num);
    int cycles;
    cycles = 0;
    while (dhit !== 1'b1 && cycles < TIMEOUT)
    begin
      @(negedge CLK);
      #2;
      cycles++;
    end
    if (dhit !== 1'b1)
    begin
      error_count++;
      timed_out = 1'b1;
      $display("request %0d got no dhit within %0d cycles", num, TIMEOUT);
    end
  endtask

  task automatic wait_for_flush();
    int cycles;
    cycles = 0;
    while (flushed !== 1'b1 && cycles < TIMEOUT)
    begin
      @(negedge CLK);
      #2;
      cycles++;
    end
    if (flushed !== 1'b1)
    begin
      error_count++;
      timed_out = 1'b1;
      $display("flushed did not rise within %0d cycles of halt", TIMEOUT);
    end
  endtask

  // wi counts words with 16 per tag and 2 per set
  task automatic run_request(input int num, input int unsigned wi, input logic is_store,
                             input cpu_types_pkg::word_t value);
    int unsigned             set;
    int unsigned             tag;
    int unsigned             way;
    int unsigned             base;
    logic                    hit;
    cpu_types_pkg::mem_req_t tr;
    set = (wi >> 1) % dcache_pkg::N_SETS;
    tag = wi >> 4;
    hit = 1'b0;
    way = model_lru[set];
    for (int w = 0; w < 2; w++)
    begin
      if (model_valid[set][w] && model_tag[set][w] == tag)
      begin
        hit = 1'b1;
        way = w;
      end
    end
    expect_q.delete();
    if (!hit)
    begin
      // dirty victim goes out before the fill
      for (int k = 0; k < 2 && model_valid[set][way] && model_dirty[set][way]; k++)
      begin
        base = model_tag[set][way] * 16 + set * 2 + k;
        tr = '0;
        tr.wen = 1'b1;
        tr.addr = base * 4;
        tr.store = ref_mem[base];
        expect_q.push_back(tr);
      end
      for (int k = 0; k < 2; k++)
      begin
        tr = '0;
        tr.ren = 1'b1;
        tr.addr = (tag * 16 + set * 2 + k) * 4;
        expect_q.push_back(tr);
      end
    end
    @(negedge CLK);
    dreq = '0;
    dreq.ren = !is_store;
    dreq.wen = is_store;
    dreq.addr = wi * 4;
    dreq.store = value;
    #2;
    compare_word($sformatf("request %0d first-cycle dhit", num), hit, dhit);
    wait_for_dhit(num);
    if (!timed_out)
    begin
      if (!is_store)
        compare_word($sformatf("request %0d load data", num), ref_mem[wi], dmemload);
      compare_word($sformatf("request %0d transfer count", num), expect_q.size(),
                   seen_q.size());
      for (int i = 0; i < expect_q.size() && i < seen_q.size(); i++)
      begin
        compare_word($sformatf("request %0d transfer %0d wen", num, i), expect_q[i].wen,
                     seen_q[i].wen);
        compare_word($sformatf("request %0d transfer %0d addr", num, i), expect_q[i].addr,
                     seen_q[i].addr);
        if (expect_q[i].wen)
          compare_word($sformatf("request %0d writeback data", num), expect_q[i].store,
                       seen_q[i].store);
      end
      // transfers from here on belong to the next request
      seen_q.delete();
      if (hit)
        model_hits++;
      else
      begin
        model_tag[set][way] = tag;
        model_valid[set][way] = 1'b1;
        model_dirty[set][way] = 1'b0;
      end
      if (is_store)
      begin
        model_dirty[set][way] = 1'b1;
        ref_mem[wi] = value;
      end
      model_lru[set] = (way == 0);
    end
  endtask

  initial
  begin
    cpu_types_pkg::word_t value;
    void'($urandom(32'h2f63_012f));
    CLK = 1'b0;
    nRST = 1'b0;
    dreq = '0;
    peek_addr = '0;
    error_count = 0;
    check_count = 0;
    timed_out = 1'b0;
    model_hits = 0;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      value = $urandom;
      ref_mem[i] = value;
      i_mem.preload(i, value);
    end
    for (int s = 0; s < dcache_pkg::N_SETS; s++)
    begin
      model_lru[s] = 1'b0;
      for (int w = 0; w < 2; w++)
      begin
        model_valid[s][w] = 1'b0;
        model_dirty[s][w] = 1'b0;
        model_tag[s][w] = '0;
      end
    end
    repeat (10) @(negedge CLK);
    nRST = 1'b1;
    #2;
    compare_word("reset dhit", 1'b0, dhit);
    compare_word("reset flushed", 1'b0, flushed);
    compare_word("reset mreq.ren", 1'b0, mreq.ren);
    compare_word("reset mreq.wen", 1'b0, mreq.wen);
    for (int n = 0; n < N_REQ && !timed_out; n++)
      run_request(n, $urandom % TEST_WORDS, $urandom % 2, $urandom);
    if (!timed_out)
    begin
      @(negedge CLK);
      dreq = '0;
      dreq.halt = 1'b1;
      wait_for_flush();
    end
    if (!timed_out)
    begin
      for (int i = 0; i < TEST_WORDS; i++)
      begin
        peek_addr = i * 4;
        #1;
        compare_word($sformatf("memory word %0d", i), ref_mem[i], peek_data);
      end
      peek_addr = dcache_pkg::HIT_COUNT_ADDR;
      #1;
      compare_word("stored hit count", model_hits, peek_data);
    end
    $display("checks: %0d, errors: %0d, predicted hits: %0d", check_count, error_count,
             model_hits);
    if (error_count == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== verilog/cpu_types_pkg.sv ====
package cpu_types_pkg;

  // datapath and bus word
  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;

  // processor side request, held stable until dhit
  typedef struct packed {
    logic  ren;
    logic  wen;
    logic  halt;
    word_t addr;
    word_t store;
  } dcache_req_t;

  // memory side request, held stable while dwait is high
  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } mem_req_t;

endpackage

// ==== verilog/dcache.sv ====
`timescale 1ns/1ps

module dcache (
  input  logic                       CLK,
  input  logic                       nRST,
  input  cpu_types_pkg::dcache_req_t dreq,
  input  logic                       dwait,
  input  cpu_types_pkg::word_t       dload,
  output logic                       dhit,
  output cpu_types_pkg::word_t       dmemload,
  output logic                       flushed,
  output cpu_types_pkg::mem_req_t    mreq
);

  dcache_pkg::dcache_addr_t      req_addr;
  dcache_pkg::dcache_addr_t      read_addr;
  dcache_pkg::frame_t            frame [2];
  dcache_pkg::frame_cmd_t        way_cmd [2];
  dcache_pkg::frame_cmd_t        fill_cmd;
  logic [1:0]                    way_hit;
  logic [dcache_pkg::N_SETS-1:0] lru;
  logic                          victim_way;
  logic                          flush_way;
  logic                          busy;
  logic                          flush_clean;
  logic                          flush_en;
  logic                          count_en;
  logic [dcache_pkg::IDX_W:0]    flush_count;
  logic                          flush_wrapped;
  cpu_types_pkg::word_t          hit_count;

  assign req_addr = dreq.addr;

  // flush walk reads the set under the walk counter
  always_comb
  begin
    read_addr = req_addr;
    if (dreq.halt)
      read_addr.idx = flush_count[dcache_pkg::IDX_W-1:0];
  end

  assign victim_way = lru[req_addr.idx];
  assign flush_way = flush_count[dcache_pkg::IDX_W];

  dcache_frame_array way0 (
    .CLK(CLK),
    .nRST(nRST),
    .idx(read_addr),
    .cmd(way_cmd[0]),
    .frame(frame[0]),
    .hit(way_hit[0])
  );

  dcache_frame_array way1 (
    .CLK(CLK),
    .nRST(nRST),
    .idx(read_addr),
    .cmd(way_cmd[1]),
    .frame(frame[1]),
    .hit(way_hit[1])
  );

  dcache_control_unit control_unit (
    .CLK(CLK),
    .nRST(nRST),
    .dreq(dreq),
    .any_hit(|way_hit),
    .victim(frame[victim_way]),
    .dwait(dwait),
    .dload(dload),
    .flush_count(flush_count),
    .flush_wrapped(flush_wrapped),
    .hit_count(hit_count),
    .flush_frame(frame[flush_way]),
    .mreq(mreq),
    .fill_cmd(fill_cmd),
    .flush_clean(flush_clean),
    .flush_en(flush_en),
    .count_en(count_en),
    .busy(busy),
    .flushed(flushed)
  );

  event_counter #(.WIDTH(32)) hit_counter (
    .CLK(CLK),
    .nRST(nRST),
    .clear(1'b0),
    .enable(count_en),
    .count(hit_count),
    .wrapped()
  );

  // walks {way, set} during the flush, parked at zero otherwise
  event_counter #(.WIDTH(dcache_pkg::IDX_W + 1)) flush_counter (
    .CLK(CLK),
    .nRST(nRST),
    .clear(!busy),
    .enable(flush_en),
    .count(flush_count),
    .wrapped(flush_wrapped)
  );

  assign dhit = (dreq.ren || dreq.wen) && (|way_hit) && !busy;
  assign dmemload = way_hit[1] ? frame[1].data[req_addr.blkoff]
                               : frame[0].data[req_addr.blkoff];

  // store hits into the hitting way, fills into the victim way
  always_comb
  begin
    for (int w = 0; w < 2; w++)
    begin
      way_cmd[w] = '0;
      if (dhit && dreq.wen && way_hit[w])
      begin
        way_cmd[w].write_word = 1'b1;
        way_cmd[w].word_sel = req_addr.blkoff;
        way_cmd[w].data = dreq.store;
      end
      else if (busy && victim_way == w[0])
        way_cmd[w] = fill_cmd;
      if (flush_clean && flush_way == w[0])
        way_cmd[w].clear_dirty = 1'b1;
    end
  end

  // lru bit names the way to replace next
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      lru <= '0;
    else if (dhit)
      lru[req_addr.idx] <= way_hit[0];
  end

  // a block lives in at most one way
  assert property (@(posedge CLK) disable iff (!nRST) !(way_hit[0] && way_hit[1]));

endmodule

// ==== verilog/dcache_control_unit.sv ====
`timescale 1ns/1ps

module dcache_control_unit (
  input  logic                        CLK,
  input  logic                        nRST,
  input  cpu_types_pkg::dcache_req_t  dreq,
  input  logic                        any_hit,
  input  dcache_pkg::frame_t          victim,
  input  logic                        dwait,
  input  cpu_types_pkg::word_t        dload,
  input  logic [dcache_pkg::IDX_W:0]  flush_count,
  input  logic                        flush_wrapped,
  input  cpu_types_pkg::word_t        hit_count,
  input  dcache_pkg::frame_t          flush_frame,
  output cpu_types_pkg::mem_req_t     mreq,
  output dcache_pkg::frame_cmd_t      fill_cmd,
  output logic                        flush_clean,
  output logic                        flush_en,
  output logic                        count_en,
  output logic                        busy,
  output logic                        flushed
);

  dcache_pkg::cu_state_t    state;
  dcache_pkg::cu_state_t    next_state;
  dcache_pkg::dcache_addr_t req_addr;
  logic                     req;
  logic                     fill_done;
  logic [dcache_pkg::IDX_W-1:0] flush_idx;

  assign req_addr = dreq.addr;
  assign req = dreq.ren || dreq.wen;
  assign flush_idx = flush_count[dcache_pkg::IDX_W-1:0];

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state <= dcache_pkg::IDLE;
      fill_done <= 1'b0;
    end
    else
    begin
      state <= next_state;
      fill_done <= (state == dcache_pkg::LD1) && !dwait;
    end
  end

  always_comb
  begin
    next_state = state;
    mreq = '0;
    fill_cmd = '0;
    fill_cmd.data = dload;
    flush_clean = 1'b0;
    flush_en = 1'b0;
    case (state)
      dcache_pkg::IDLE:
      begin
        if (dreq.halt)
          next_state = dcache_pkg::FLUSH_CHECK;
        else if (req && !any_hit)
          next_state = (victim.valid && victim.dirty) ? dcache_pkg::WB0 : dcache_pkg::LD0;
      end
      dcache_pkg::WB0, dcache_pkg::WB1:
      begin
        mreq.wen = 1'b1;
        mreq.addr = {victim.tag, req_addr.idx, state == dcache_pkg::WB1, 2'b00};
        mreq.store = victim.data[state == dcache_pkg::WB1];
        if (!dwait)
          next_state = (state == dcache_pkg::WB0) ? dcache_pkg::WB1 : dcache_pkg::LD0;
      end
      dcache_pkg::LD0, dcache_pkg::LD1:
      begin
        mreq.ren = 1'b1;
        mreq.addr = {req_addr.tag, req_addr.idx, state == dcache_pkg::LD1, 2'b00};
        fill_cmd.word_sel = (state == dcache_pkg::LD1);
        if (!dwait)
        begin
          fill_cmd.fill_word = 1'b1;
          // tag, valid and clean only once the block is complete
          if (state == dcache_pkg::LD1)
          begin
            fill_cmd.write_tag = 1'b1;
            fill_cmd.set_valid = 1'b1;
            fill_cmd.clear_dirty = 1'b1;
            next_state = dcache_pkg::IDLE;
          end
          else
            next_state = dcache_pkg::LD1;
        end
      end
      dcache_pkg::FLUSH_CHECK:
      begin
        if (flush_frame.valid && flush_frame.dirty)
          next_state = dcache_pkg::FLUSH_WB0;
        else
        begin
          flush_en = 1'b1;
          if (flush_wrapped)
            next_state = dcache_pkg::STORE_COUNT;
        end
      end
      dcache_pkg::FLUSH_WB0, dcache_pkg::FLUSH_WB1:
      begin
        mreq.wen = 1'b1;
        mreq.addr = {flush_frame.tag, flush_idx, state == dcache_pkg::FLUSH_WB1, 2'b00};
        mreq.store = flush_frame.data[state == dcache_pkg::FLUSH_WB1];
        if (!dwait)
        begin
          if (state == dcache_pkg::FLUSH_WB0)
            next_state = dcache_pkg::FLUSH_WB1;
          else
          begin
            flush_clean = 1'b1;
            flush_en = 1'b1;
            next_state = flush_wrapped ? dcache_pkg::STORE_COUNT : dcache_pkg::FLUSH_CHECK;
          end
        end
      end
      dcache_pkg::STORE_COUNT:
      begin
        mreq.wen = 1'b1;
        mreq.addr = dcache_pkg::HIT_COUNT_ADDR;
        mreq.store = hit_count;
        if (!dwait)
          next_state = dcache_pkg::DONE;
      end
      default:
        next_state = state;
    endcase
  end

  // the hit right after a fill belongs to the miss
  assign count_en = (state == dcache_pkg::IDLE) && req && any_hit && !fill_done;
  assign busy = (state != dcache_pkg::IDLE);
  assign flushed = (state == dcache_pkg::DONE);

  assert property (@(posedge CLK) disable iff (!nRST) !(mreq.ren && mreq.wen));

  // bus request must not move while the memory stalls
  assert property (@(posedge CLK) disable iff (!nRST)
    (mreq.ren || mreq.wen) && dwait |=> $stable(mreq));

endmodule

// ==== verilog/dcache_frame_array.sv ====
`timescale 1ns/1ps

module dcache_frame_array (
  input  logic                     CLK,
  input  logic                     nRST,
  input  dcache_pkg::dcache_addr_t idx,
  input  dcache_pkg::frame_cmd_t   cmd,
  output dcache_pkg::frame_t       frame,
  output logic                     hit
);

  logic [dcache_pkg::N_SETS-1:0] valid;
  logic [dcache_pkg::N_SETS-1:0] dirty;
  logic [dcache_pkg::TAG_W-1:0]  tags [dcache_pkg::N_SETS];
  cpu_types_pkg::word_t [dcache_pkg::N_WORDS-1:0] data_mem [dcache_pkg::N_SETS];

  // status bits
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      valid <= '0;
      dirty <= '0;
    end
    else
    begin
      if (cmd.set_valid)
        valid[idx.idx] <= 1'b1;
      if (cmd.write_word)
        dirty[idx.idx] <= 1'b1;
      else if (cmd.clear_dirty)
        dirty[idx.idx] <= 1'b0;
    end
  end

  // tag and data storage
  always_ff @(posedge CLK)
  begin
    if (cmd.write_word || cmd.fill_word)
      data_mem[idx.idx][cmd.word_sel] <= cmd.data;
    if (cmd.write_tag)
      tags[idx.idx] <= idx.tag;
  end

  always_comb
  begin
    frame.valid = valid[idx.idx];
    frame.dirty = dirty[idx.idx];
    frame.tag = tags[idx.idx];
    frame.data = data_mem[idx.idx];
  end

  assign hit = frame.valid && (frame.tag == idx.tag);

  assert property (@(posedge CLK) disable iff (!nRST) !(cmd.write_word && cmd.fill_word));

endmodule

// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

  // geometry
  localparam int N_SETS = 8;
  localparam int N_WORDS = 2;
  localparam int TAG_W = 26;
  localparam int IDX_W = 3;

  // hit count lands here at the end of a flush
  localparam cpu_types_pkg::word_t HIT_COUNT_ADDR = 32'h0000_3100;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] idx;
    logic             blkoff;
    logic [1:0]       byteoff;
  } dcache_addr_t;

  typedef struct packed {
    logic                                valid;
    logic                                dirty;
    logic [TAG_W-1:0]                    tag;
    cpu_types_pkg::word_t [N_WORDS-1:0] data;
  } frame_t;

  // write command into one way
  typedef struct packed {
    logic                 write_word;
    logic                 fill_word;
    logic                 set_valid;
    logic                 clear_dirty;
    logic                 write_tag;
    logic                 word_sel;
    cpu_types_pkg::word_t data;
  } frame_cmd_t;

  typedef enum logic [3:0] {
    IDLE,
    WB0,
    WB1,
    LD0,
    LD1,
    FLUSH_CHECK,
    FLUSH_WB0,
    FLUSH_WB1,
    STORE_COUNT,
    DONE
  } cu_state_t;

endpackage

// ==== verilog/event_counter.sv ====
`timescale 1ns/1ps

module event_counter #(
  parameter int WIDTH = 32
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             clear,
  input  logic             enable,
  output logic [WIDTH-1:0] count,
  output logic             wrapped
);

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      count <= '0;
    else if (clear)
      count <= '0;
    else if (enable)
      count <= count + 1'b1;
  end

  // high in the cycle the count rolls over to zero
  assign wrapped = enable && (&count);

  assert property (@(posedge CLK) disable iff (!nRST) !(clear && enable));

endmodule
